/* hw/mdio_defs.svh */
// MDIO master shared constants
// Bus field widths, host register offsets and default MDC divider
`ifndef MDIO_DEFS_SVH
`define MDIO_DEFS_SVH

// One data or address word on the MDIO bus
`define MDIO_WORD_W 16

// Operation register: c45 flag, opcode, port address, device address
`define MDIO_OP_W 13

`define MDIO_PREAMBLE_BITS 32

`define MDIO_REG_DATA 'h0
`define MDIO_REG_ADDR 'h4
`define MDIO_REG_OP   'h8
`define MDIO_REG_CTRL 'hC

`define MDIO_DEF_MDC_DIVIDER 200

`endif

/* hw/mdio_pkg.sv */
// MDIO master types
// Bus words, the operation word layout and the frame phases
`default_nettype none

`include "mdio_defs.svh"

package mdio_pkg;

   typedef logic [`MDIO_WORD_W-1:0] mdio_word_t;

   // Field order matches the register layout, c45 flag in bit 12
   typedef struct packed {
      logic       c45;
      logic [1:0] opcode;
      logic [4:0] prtad;
      logic [4:0] devad;
   } mdio_op_t;

   typedef logic [31:0] reg_word_t;

   typedef enum logic [2:0] {
      PH_IDLE,
      PH_PREAMBLE,
      PH_START,
      PH_COMMAND,
      PH_TURNAROUND,
      PH_DATA,
      PH_POST
   } mdio_phase_e;

endpackage

`default_nettype wire

/* hw/mdio_regs.sv */
// MDIO master host registers
// Holds data, address and operation words and the running flag
`timescale 1ns/100ps
`default_nettype none

`include "mdio_defs.svh"

module mdio_regs #(
   parameter mdio_pkg::reg_word_t reg_base = '0
) (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       wr_req,
   input  wire mdio_pkg::reg_word_t  wr_addr,
   input  wire mdio_pkg::reg_word_t  wr_data,
   input  wire                       rd_req,
   input  wire mdio_pkg::reg_word_t  rd_addr,
   output logic                      rd_resp,
   output mdio_pkg::reg_word_t       rd_data,
   input  wire                       frame_done,
   input  wire mdio_pkg::mdio_word_t rd_word,
   output logic                      running,
   output mdio_pkg::mdio_op_t        op,
   output mdio_pkg::mdio_word_t      wr_word,
   output mdio_pkg::mdio_word_t      addr_word
);

   localparam mdio_pkg::reg_word_t addr_data = reg_base + `MDIO_REG_DATA;
   localparam mdio_pkg::reg_word_t addr_addr = reg_base + `MDIO_REG_ADDR;
   localparam mdio_pkg::reg_word_t addr_op   = reg_base + `MDIO_REG_OP;
   localparam mdio_pkg::reg_word_t addr_ctrl = reg_base + `MDIO_REG_CTRL;

   logic hit;

   // The data register is shared by both directions. A host write loads
   // the word to send, and the end of a read frame replaces it with the
   // word taken from the PHY
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_word   <= '0;
         addr_word <= '0;
         op        <= '0;
         running   <= 1'b0;
      end else begin
         if (frame_done) begin
            running <= 1'b0;
            if (op.opcode[1]) begin
               wr_word <= rd_word;
            end
         end
         if (wr_req) begin
            case (wr_addr)
               addr_data: wr_word   <= wr_data[`MDIO_WORD_W-1:0];
               addr_addr: addr_word <= wr_data[`MDIO_WORD_W-1:0];
               addr_op:   op        <= mdio_pkg::mdio_op_t'(wr_data[`MDIO_OP_W-1:0]);
               addr_ctrl: begin
                  // Start request, the frame engine picks it up on the next MDC fall
                  if (wr_data[0]) begin
                     running <= 1'b1;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      hit = (rd_addr == addr_data) || (rd_addr == addr_addr) ||
            (rd_addr == addr_op) || (rd_addr == addr_ctrl);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_resp <= 1'b0;
      end else begin
         rd_resp <= rd_req && hit;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_req) begin
         case (rd_addr)
            addr_data: rd_data <= mdio_pkg::reg_word_t'(wr_word);
            addr_addr: rd_data <= mdio_pkg::reg_word_t'(addr_word);
            addr_op:   rd_data <= mdio_pkg::reg_word_t'(op);
            addr_ctrl: rd_data <= mdio_pkg::reg_word_t'(running);
            default:   rd_data <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/mdc_gen.sv */
// MDC clock generator
// Divides clk evenly and flags each falling edge of mdc
`timescale 1ns/100ps
`default_nettype none

`include "mdio_defs.svh"

module mdc_gen #(
   parameter int mdc_divider = `MDIO_DEF_MDC_DIVIDER
) (
   input  wire  clk,
   input  wire  rst,
   output logic mdc,
   output logic mdc_fall
);

   localparam int half  = mdc_divider / 2;
   localparam int cnt_w = (half > 1) ? $clog2(half) : 1;

   logic [cnt_w-1:0] half_cnt;
   logic             mdc_d;

   always_ff @(posedge clk) begin
      if (rst) begin
         half_cnt <= '0;
         mdc      <= 1'b0;
         mdc_d    <= 1'b0;
         mdc_fall <= 1'b0;
      end else begin
         mdc_d    <= mdc;
         // Strobe lands one clk after mdc has gone low
         mdc_fall <= mdc_d & ~mdc;
         if (half_cnt == cnt_w'(half - 1)) begin
            half_cnt <= '0;
            mdc      <= ~mdc;
         end else begin
            half_cnt <= half_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/mdio_frame.sv */
// MDIO frame engine
// Serializes Clause 22 and Clause 45 frames on each MDC fall and
// captures read data from the PHY
`timescale 1ns/100ps
`default_nettype none

`include "mdio_defs.svh"

module mdio_frame (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       mdc_fall,
   input  wire                       running,
   input  wire mdio_pkg::mdio_op_t   op,
   input  wire mdio_pkg::mdio_word_t wr_word,
   input  wire mdio_pkg::mdio_word_t addr_word,
   input  wire                       mdio_in,
   output logic                      mdio_out,
   output logic                      mdio_tri,
   output logic                      frame_done,
   output mdio_pkg::mdio_word_t      rd_word
);

   // Bit positions within the frame, counted from the first preamble bit
   localparam int pre_last  = `MDIO_PREAMBLE_BITS - 1;
   localparam int start_bit = `MDIO_PREAMBLE_BITS;
   localparam int cmd_last  = start_bit + 2 + `MDIO_OP_W - 2;
   localparam int ta_first  = cmd_last + 1;
   localparam int last_bit  = ta_first + 2 + `MDIO_WORD_W - 1;
   localparam int bit_w     = $clog2(last_bit + 1);

   mdio_pkg::mdio_phase_e phase;
   logic [bit_w-1:0]      bit_cnt;
   mdio_pkg::mdio_word_t  shreg;
   logic                  is_read;
   logic                  is_addr;

   // Both clauses read when the upper opcode bit is set
   always_comb begin
      is_read = op.opcode[1];
      is_addr = op.c45 && (op.opcode == 2'b00);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         phase      <= mdio_pkg::PH_IDLE;
         bit_cnt    <= '0;
         mdio_out   <= 1'b0;
         mdio_tri   <= 1'b1;
         frame_done <= 1'b0;
         rd_word    <= '0;
      end else begin
         frame_done <= 1'b0;
         if (mdc_fall) begin
            bit_cnt <= bit_cnt + 1'b1;
            case (phase)
               mdio_pkg::PH_IDLE: begin
                  bit_cnt  <= '0;
                  mdio_tri <= 1'b1;
                  mdio_out <= 1'b0;
                  if (running) begin
                     phase    <= mdio_pkg::PH_PREAMBLE;
                     mdio_tri <= 1'b0;
                     mdio_out <= 1'b1;
                  end
               end
               mdio_pkg::PH_PREAMBLE: begin
                  if (bit_cnt == bit_w'(pre_last)) begin
                     phase    <= mdio_pkg::PH_START;
                     mdio_out <= 1'b0;
                  end
               end
               mdio_pkg::PH_START: begin
                  // Second start bit is 1 for Clause 22 and 0 for Clause 45
                  if (bit_cnt == bit_w'(start_bit)) begin
                     mdio_out <= ~op.c45;
                  end else begin
                     phase    <= mdio_pkg::PH_COMMAND;
                     mdio_out <= op.opcode[1];
                     shreg    <= {op.opcode[0], op.prtad, op.devad, 5'b00000};
                  end
               end
               mdio_pkg::PH_COMMAND: begin
                  if (bit_cnt == bit_w'(cmd_last)) begin
                     phase    <= mdio_pkg::PH_TURNAROUND;
                     mdio_tri <= is_read;
                     mdio_out <= ~is_read;
                     shreg    <= is_addr ? addr_word : wr_word;
                  end else begin
                     mdio_out <= shreg[`MDIO_WORD_W-1];
                     shreg    <= shreg << 1;
                  end
               end
               mdio_pkg::PH_TURNAROUND: begin
                  if (bit_cnt == bit_w'(ta_first)) begin
                     mdio_out <= 1'b0;
                  end else begin
                     phase <= mdio_pkg::PH_DATA;
                     // PHY put data bit 15 on the pin during this turnaround bit
                     if (is_read) begin
                        rd_word <= {rd_word[`MDIO_WORD_W-2:0], mdio_in};
                     end else begin
                        mdio_out <= shreg[`MDIO_WORD_W-1];
                        shreg    <= shreg << 1;
                     end
                  end
               end
               mdio_pkg::PH_DATA: begin
                  if (bit_cnt == bit_w'(last_bit)) begin
                     phase      <= mdio_pkg::PH_POST;
                     mdio_tri   <= 1'b1;
                     mdio_out   <= 1'b0;
                     frame_done <= 1'b1;
                  end else if (is_read) begin
                     rd_word <= {rd_word[`MDIO_WORD_W-2:0], mdio_in};
                  end else begin
                     mdio_out <= shreg[`MDIO_WORD_W-1];
                     shreg    <= shreg << 1;
                  end
               end
               default: begin
                  // Post bit gives the register block time to drop running
                  phase   <= mdio_pkg::PH_IDLE;
                  bit_cnt <= '0;
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* hw/mdio_master.sv */
// MDIO management master top level
// Host registers, MDC generation and the frame engine
`timescale 1ns/100ps
`default_nettype none

`include "mdio_defs.svh"

module mdio_master #(
   parameter int                  mdc_divider = `MDIO_DEF_MDC_DIVIDER,
   parameter mdio_pkg::reg_word_t reg_base    = '0
) (
   input  wire                      clk,
   input  wire                      rst,
   input  wire                      wr_req,
   input  wire mdio_pkg::reg_word_t wr_addr,
   input  wire mdio_pkg::reg_word_t wr_data,
   input  wire                      rd_req,
   input  wire mdio_pkg::reg_word_t rd_addr,
   output wire                      rd_resp,
   output mdio_pkg::reg_word_t      rd_data,
   output wire                      mdc,
   output wire                      mdio_out,
   output wire                      mdio_tri,
   input  wire                      mdio_in
);

   logic                 running;
   logic                 mdc_fall;
   logic                 frame_done;
   mdio_pkg::mdio_op_t   op;
   mdio_pkg::mdio_word_t wr_word;
   mdio_pkg::mdio_word_t addr_word;
   mdio_pkg::mdio_word_t rd_word;

   mdio_regs #(
      .reg_base   (reg_base)
   ) mdio_regs_i (
      .clk        (clk),
      .rst        (rst),
      .wr_req     (wr_req),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .rd_req     (rd_req),
      .rd_addr    (rd_addr),
      .rd_resp    (rd_resp),
      .rd_data    (rd_data),
      .frame_done (frame_done),
      .rd_word    (rd_word),
      .running    (running),
      .op         (op),
      .wr_word    (wr_word),
      .addr_word  (addr_word)
   );

   mdc_gen #(
      .mdc_divider (mdc_divider)
   ) mdc_gen_i (
      .clk      (clk),
      .rst      (rst),
      .mdc      (mdc),
      .mdc_fall (mdc_fall)
   );

   mdio_frame mdio_frame_i (
      .clk        (clk),
      .rst        (rst),
      .mdc_fall   (mdc_fall),
      .running    (running),
      .op         (op),
      .wr_word    (wr_word),
      .addr_word  (addr_word),
      .mdio_in    (mdio_in),
      .mdio_out   (mdio_out),
      .mdio_tri   (mdio_tri),
      .frame_done (frame_done),
      .rd_word    (rd_word)
   );

endmodule

`default_nettype wire

/* tb/tb_mdio_master.sv */
// MDIO master testbench
// Plays a transaction trace through the host registers against a PHY bus model
`timescale 1ns/100ps
`default_nettype none

`include "mdio_defs.svh"

module tb_mdio_master;

   localparam int trace_words = 140;
   localparam int poll_limit  = 1000;
   localparam int resp_limit  = 4;
   localparam int start_limit = 40;
   localparam int clk_period  = 20;
   localparam int mdc_div     = 8;
   localparam int mdc_limit   = 2 * mdc_div;

   logic        clk = 1'b0;
   logic        rst;
   logic        wr_req;
   logic [31:0] wr_addr;
   logic [31:0] wr_data;
   logic        rd_req;
   logic [31:0] rd_addr;
   wire         rd_resp;
   wire  [31:0] rd_data;
   wire         mdc;
   wire         mdio_out;
   wire         mdio_tri;
   logic        mdio_in;

   logic [15:0] trace_mem [0:trace_words-1];
   logic        frame_out [0:63];
   logic        frame_tri [0:63];
   int          errors = 0;
   int          test_errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   mdio_master #(
      .mdc_divider (mdc_div)
   ) mdio_master_i (
      .clk      (clk),
      .rst      (rst),
      .wr_req   (wr_req),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .rd_req   (rd_req),
      .rd_addr  (rd_addr),
      .rd_resp  (rd_resp),
      .rd_data  (rd_data),
      .mdc      (mdc),
      .mdio_out (mdio_out),
      .mdio_tri (mdio_tri),
      .mdio_in  (mdio_in)
   );

   always #10 clk = ~clk;

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
      errors++;
      test_errors++;
   endtask

   task automatic report_problem(input string msg);
      $display("time %0t ns: %s", $time, msg);
      errors++;
      test_errors++;
   endtask

   task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
      @(posedge clk);
      #2;
      wr_req  = 1'b1;
      wr_addr = addr;
      wr_data = data;
      @(posedge clk);
      #2;
      wr_req = 1'b0;
   endtask

   // Returns the response latency in cycles, or 0 when no response came
   task automatic reg_read(input logic [31:0] addr, output logic [31:0] data, output int lat);
      int n;
      n    = 0;
      lat  = 0;
      data = '0;
      @(posedge clk);
      #2;
      rd_req  = 1'b1;
      rd_addr = addr;
      while (lat == 0 && n < resp_limit) begin
         @(posedge clk);
         #2;
         rd_req = 1'b0;
         n++;
         if (rd_resp === 1'b1) begin
            lat  = n;
            data = rd_data;
         end
      end
   endtask

   task automatic read_and_compare(input logic [31:0] addr, input string name,
                                   input logic [31:0] exp);
      logic [31:0] got;
      int          lat;
      reg_read(addr, got, lat);
      if (lat == 0) begin
         report_problem($sformatf("no rd_resp for a read of address %h", addr));
      end else begin
         if (lat != 1) begin
            report_mismatch("rd_resp latency", 32'd1, lat);
         end
         if (got !== exp) begin
            report_mismatch(name, exp, got);
         end
      end
   endtask

   // Next MDC rise, seen just after the clk edge that raises it
   task automatic wait_mdc_rise(output logic ok);
      int   n;
      logic prev;
      n    = 0;
      ok   = 1'b0;
      prev = mdc;
      while (!ok && n < mdc_limit) begin
         @(posedge clk);
         #1;
         n++;
         if (prev === 1'b0 && mdc === 1'b1) begin
            ok = 1'b1;
         end
         prev = mdc;
      end
   endtask

   // PHY side of one frame. Bit n is the one on the pin at the n-th MDC
   // rise, and read data goes out just after rises 47 to 62
   task automatic phy_frame(input logic [15:0] word);
      int          waits;
      int          n;
      logic        seen;
      logic        ok;
      time         t_first;
      time         t_last;
      logic [31:0] span;
      waits   = 0;
      seen    = 1'b0;
      ok      = 1'b1;
      t_first = 0;
      t_last  = 0;
      while (ok && !seen && waits < start_limit) begin
         wait_mdc_rise(ok);
         waits++;
         if (ok && mdio_tri === 1'b0) begin
            seen = 1'b1;
         end
      end
      if (!seen) begin
         report_problem("PHY model saw no frame start on the bus");
      end else begin
         t_first = $time;
         n       = 0;
         while (ok && n < 64) begin
            if (n > 0) begin
               wait_mdc_rise(ok);
            end
            if (ok) begin
               t_last       = $time;
               frame_out[n] = mdio_out;
               frame_tri[n] = mdio_tri;
               if (n >= 47 && n <= 62) begin
                  #1;
                  mdio_in = word[62-n];
               end
               n++;
            end
         end
         span = 32'(t_last - t_first);
         if (!ok) begin
            report_problem("MDC stopped toggling during a frame");
         end else if (span != 63 * mdc_div * clk_period) begin
            report_mismatch("MDC time over 63 bits", 63 * mdc_div * clk_period, span);
         end
         #1;
         mdio_in = 1'b1;
      end
   endtask

   task automatic run_frame(input logic is_rd, input logic c45, input logic [1:0] opc,
                            input logic [4:0] prt, input logic [4:0] dev,
                            input logic [15:0] data, input logic [15:0] xword);
      logic [63:0] exp_bits;
      logic [15:0] sent;
      logic [31:0] ctrl;
      logic        busy;
      int          lat;
      int          polls;
      int          n;
      // Clause 45 address frames carry the address register
      sent     = (c45 && opc == 2'b00) ? xword : data;
      exp_bits = {32'hffff_ffff, 1'b0, ~c45, opc, prt, dev, 2'b10, sent};
      for (n = 0; n < 64; n++) begin
         frame_out[n] = 1'bx;
         frame_tri[n] = 1'bx;
      end
      reg_write(`MDIO_REG_DATA, {16'h0, data});
      reg_write(`MDIO_REG_ADDR, {16'h0, xword});
      reg_write(`MDIO_REG_OP, {19'h0, c45, opc, prt, dev});
      fork
         phy_frame(is_rd ? xword : 16'h0);
         begin
            reg_write(`MDIO_REG_CTRL, 32'h1);
            read_and_compare(`MDIO_REG_CTRL, "running after start", 32'h1);
            polls = 0;
            busy  = 1'b1;
            while (busy && polls < poll_limit) begin
               reg_read(`MDIO_REG_CTRL, ctrl, lat);
               polls++;
               if (lat != 0 && ctrl[0] === 1'b0) begin
                  busy = 1'b0;
               end
            end
            if (busy) begin
               report_problem("running did not clear after the frame");
            end
         end
      join
      for (n = 0; n < 64; n++) begin
         if (is_rd && n >= 46) begin
            if (frame_tri[n] !== 1'b1) begin
               report_mismatch($sformatf("mdio_tri bit %0d", n), 32'd1, 32'(frame_tri[n]));
            end
         end else begin
            if (frame_tri[n] !== 1'b0) begin
               report_mismatch($sformatf("mdio_tri bit %0d", n), 32'd0, 32'(frame_tri[n]));
            end
            if (frame_out[n] !== exp_bits[63-n]) begin
               report_mismatch($sformatf("mdio_out bit %0d", n), 32'(exp_bits[63-n]),
                               32'(frame_out[n]));
            end
         end
      end
      if (is_rd) begin
         read_and_compare(`MDIO_REG_DATA, "data register", {16'h0, xword});
      end
   endtask

   // Upper bits are written as ones so the readback shows zero extension
   task automatic run_readback(input logic c45, input logic [1:0] opc, input logic [4:0] prt,
                               input logic [4:0] dev, input logic [15:0] data,
                               input logic [15:0] xword);
      logic [12:0] opw;
      logic [31:0] got;
      int          lat;
      opw = {c45, opc, prt, dev};
      reg_write(`MDIO_REG_DATA, {16'hffff, data});
      reg_write(`MDIO_REG_ADDR, {16'hffff, xword});
      reg_write(`MDIO_REG_OP, {19'h7ffff, opw});
      read_and_compare(`MDIO_REG_DATA, "data register", {16'h0, data});
      read_and_compare(`MDIO_REG_ADDR, "address register", {16'h0, xword});
      read_and_compare(`MDIO_REG_OP, "op register", {19'h0, opw});
      read_and_compare(`MDIO_REG_CTRL, "control register", 32'h0);
      reg_read(32'h10, got, lat);
      if (lat != 0) begin
         report_problem("a read of unmapped address 10 got a response");
      end
   endtask

   function automatic string kind_name(input logic [15:0] kind);
      case (kind)
         16'h1:   return "write frame";
         16'h2:   return "read frame";
         16'h3:   return "register readback";
         default: return "unknown";
      endcase
   endfunction

   task automatic close_test(input int idx, input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %0d %s: ok", idx, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", idx, name, test_errors);
      end
   endtask

   initial begin
      int          i;
      int          base;
      logic        done;
      logic [15:0] kind;
      logic        c45;
      logic [1:0]  opc;
      logic [4:0]  prt;
      logic [4:0]  dev;
      rst     = 1'b1;
      wr_req  = 1'b0;
      wr_addr = '0;
      wr_data = '0;
      rd_req  = 1'b0;
      rd_addr = '0;
      mdio_in = 1'b1;
      $readmemh("tb/mdio_trace.txt", trace_mem);
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;

      test_errors = 0;
      if (mdio_tri !== 1'b1) begin
         report_mismatch("mdio_tri", 32'd1, 32'(mdio_tri));
      end
      if (mdio_out !== 1'b0) begin
         report_mismatch("mdio_out", 32'd0, 32'(mdio_out));
      end
      if (mdc !== 1'b0) begin
         report_mismatch("mdc", 32'd0, 32'(mdc));
      end
      if (rd_resp !== 1'b0) begin
         report_mismatch("rd_resp", 32'd0, 32'(rd_resp));
      end
      read_and_compare(`MDIO_REG_CTRL, "control register", 32'h0);
      close_test(0, "reset state");

      i    = 0;
      done = 1'b0;
      while (!done && (i + 1) * 7 <= trace_words) begin
         base = i * 7;
         kind = trace_mem[base];
         if (kind === 16'h0) begin
            done = 1'b1;
         end else begin
            c45         = trace_mem[base+1][0];
            opc         = trace_mem[base+2][1:0];
            prt         = trace_mem[base+3][4:0];
            dev         = trace_mem[base+4][4:0];
            test_errors = 0;
            case (kind)
               16'h1: run_frame(1'b0, c45, opc, prt, dev, trace_mem[base+5], trace_mem[base+6]);
               16'h2: run_frame(1'b1, c45, opc, prt, dev, trace_mem[base+5], trace_mem[base+6]);
               16'h3: run_readback(c45, opc, prt, dev, trace_mem[base+5], trace_mem[base+6]);
               default: report_problem($sformatf("trace entry %0d has unknown kind %h", i, kind));
            endcase
            close_test(i + 1, kind_name(kind));
            i++;
         end
      end

      $display("%0d tests, %0d ok, %0d failed, %0d errors", tests_run,
               tests_run - tests_failed, tests_failed, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb/mdio_trace.txt */
// MDIO transaction trace, one transaction per line, all fields hex
// kind c45 opcode prtad devad data xword
// kind: 1 write frame, 2 read frame, 3 register readback, 0 end of trace
// xword: word the PHY returns in reads, address register word otherwise
// Clause 22 writes
1 0 1 01 00 a5c3 0000
1 0 1 1f 1f ffff 0000
1 0 1 00 0a 0001 8000
// Clause 45 address frames send xword, Clause 45 writes send data
1 1 0 03 01 1234 8001
1 1 1 03 01 beef 0000
1 1 0 1f 07 0000 ffff
// Clause 22 reads
2 0 2 01 02 0000 7e81
2 0 2 10 05 ffff 0000
2 0 2 0a 11 1111 a5a5
// Clause 45 read and post-read-increment
2 1 3 03 01 5555 c3a5
2 1 2 07 1e 0000 ffff
// Register readback
3 1 3 15 0c 9abc 4321
3 0 0 00 00 0000 0000
3 0 3 1f 1f ffff ffff
// End of trace
0 0 0 00 00 0000 0000

/* list.f */
+incdir+hw
hw/mdio_pkg.sv
hw/mdio_regs.sv
hw/mdc_gen.sv
hw/mdio_frame.sv
hw/mdio_master.sv
tb/tb_mdio_master.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_mdio_master
FILELIST  = list.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
